// File: verilog/csr_pkg.sv
package csr_pkg;

    // machine word width
    parameter int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;

    // csr index space
    parameter int CSR_ADDR_W = 12;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    parameter csr_addr_t ADDR_MSTATUS = 12'h300;
    parameter csr_addr_t ADDR_MTVEC   = 12'h305;
    parameter csr_addr_t ADDR_MEPC    = 12'h341;
    parameter csr_addr_t ADDR_MCAUSE  = 12'h342;

    // write/set/clear forms of the csr instructions
    typedef enum logic [1:0] {
        CSR_NONE  = 2'b00,
        CSR_CLEAR = 2'b01,
        CSR_WRITE = 2'b10,
        CSR_SET   = 2'b11
    } csr_op_t;

    // reset values
    // mstatus comes up with MPP = M and SXL/UXL = 64 bit
    parameter xlen_t MSTATUS_RESET = 64'h0000_000A_0000_1800;
    parameter xlen_t MEPC_RESET    = 64'h0000_0000_8000_0000;
    parameter xlen_t MTVEC_RESET   = '0;
    parameter xlen_t MCAUSE_RESET  = '0;

    // mstatus fields in use
    parameter int MIE_BIT  = 3;
    parameter int MPIE_BIT = 7;

endpackage

// File: verilog/trap_pkg.sv
package trap_pkg;

    // cause values are full width words
    typedef csr_pkg::xlen_t cause_t;

    // interrupt bit sits in the msb of mcause
    parameter cause_t INT_FLAG = {1'b1, {(csr_pkg::XLEN-1){1'b0}}};

    // exception codes
    parameter cause_t CAUSE_ILLEGAL    = 2;
    parameter cause_t CAUSE_BREAKPOINT = 3;
    parameter cause_t CAUSE_ECALL_M    = 11;

    // interrupt code, combined with INT_FLAG when taken
    parameter cause_t CAUSE_TIMER_M    = 7;

    // mtvec mode field
    parameter logic [1:0] MODE_DIRECT   = 2'b00;
    parameter logic [1:0] MODE_VECTORED = 2'b01;

    // redirect sequencing
    typedef enum logic [1:0] {
        ST_IDLE     = 2'b00,
        ST_REDIRECT = 2'b01
    } trap_state_t;

endpackage

// File: verilog/csr_reg.sv
`timescale 1ns/10ps

module csr_reg #(
    parameter int XLEN = 64
) (
    input  logic                clk,
    input  logic                rst_n,

    // csr instruction port
    input  csr_pkg::csr_addr_t  csr_addr,
    input  csr_pkg::csr_op_t    csr_op,
    input  logic                csr_wen,
    input  csr_pkg::xlen_t      rs1,
    output csr_pkg::xlen_t      csr_rdata,

    // trap side
    input  logic                trap_enter,
    input  logic                trap_return,
    input  trap_pkg::cause_t    trap_cause,
    input  csr_pkg::xlen_t      trap_epc,

    output csr_pkg::xlen_t      csr_mtvec,
    output csr_pkg::xlen_t      csr_mepc,
    output logic                int_en
);

    csr_pkg::xlen_t mstatus;
    csr_pkg::xlen_t mtvec;
    csr_pkg::xlen_t mepc;
    csr_pkg::xlen_t mcause;

    csr_pkg::xlen_t mstatus_nxt;
    csr_pkg::xlen_t wdata;

    logic sel_mstatus;
    logic sel_mtvec;
    logic sel_mepc;
    logic sel_mcause;
    logic wr_en;

    // address decode
    assign sel_mstatus = (csr_addr == csr_pkg::ADDR_MSTATUS);
    assign sel_mtvec   = (csr_addr == csr_pkg::ADDR_MTVEC);
    assign sel_mepc    = (csr_addr == csr_pkg::ADDR_MEPC);
    assign sel_mcause  = (csr_addr == csr_pkg::ADDR_MCAUSE);

    // trap pulse wins, the instruction write is lost
    assign wr_en = csr_wen & ~(trap_enter | trap_return);

    // write data from the op and the current value
    always_comb begin
        case (csr_op)
            csr_pkg::CSR_WRITE: wdata = rs1;
            csr_pkg::CSR_SET:   wdata = csr_rdata | rs1;
            csr_pkg::CSR_CLEAR: wdata = csr_rdata & ~rs1;
            default:            wdata = '0;
        endcase
    end

    // MIE/MPIE stacking
    always_comb begin
        mstatus_nxt = mstatus;
        if (trap_enter) begin
            mstatus_nxt[csr_pkg::MPIE_BIT] = mstatus[csr_pkg::MIE_BIT];
            mstatus_nxt[csr_pkg::MIE_BIT]  = 1'b0;
        end else if (trap_return) begin
            mstatus_nxt[csr_pkg::MIE_BIT]  = mstatus[csr_pkg::MPIE_BIT];
            mstatus_nxt[csr_pkg::MPIE_BIT] = 1'b1;
        end else if (wr_en && sel_mstatus) begin
            mstatus_nxt = wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus <= csr_pkg::MSTATUS_RESET;
        end else begin
            mstatus <= mstatus_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtvec <= csr_pkg::MTVEC_RESET;
        end else if (wr_en && sel_mtvec) begin
            mtvec <= wdata;
        end
    end

    // mret leaves mepc and mcause alone
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mepc   <= csr_pkg::MEPC_RESET;
            mcause <= csr_pkg::MCAUSE_RESET;
        end else if (trap_enter) begin
            mepc   <= trap_epc;
            mcause <= trap_cause;
        end else begin
            if (wr_en && sel_mepc) begin
                mepc <= wdata;
            end
            if (wr_en && sel_mcause) begin
                mcause <= wdata;
            end
        end
    end

    // unmapped index reads zero
    assign csr_rdata = ({XLEN{sel_mstatus}} & mstatus)
                     | ({XLEN{sel_mtvec}}   & mtvec)
                     | ({XLEN{sel_mepc}}    & mepc)
                     | ({XLEN{sel_mcause}}  & mcause);

    assign csr_mtvec = mtvec;
    assign csr_mepc  = mepc;
    assign int_en    = mstatus[csr_pkg::MIE_BIT];

endmodule

// File: verilog/mtimer.sv
`timescale 1ns/10ps

module mtimer #(
    parameter int MTIME_DIV = 4
) (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            mtimecmp_wen,
    input  csr_pkg::xlen_t  mtimecmp_wdata,

    output csr_pkg::xlen_t  mtime,
    output logic            timer_pending
);

    localparam int DIV_W = (MTIME_DIV > 1) ? $clog2(MTIME_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    csr_pkg::xlen_t   mtimecmp;

    // one tick every MTIME_DIV clocks
    assign tick = (div_cnt == DIV_W'(MTIME_DIV - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (tick) begin
            mtime <= mtime + 1'b1;
        end
    end

    // all ones keeps the compare quiet out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtimecmp <= '1;
        end else if (mtimecmp_wen) begin
            mtimecmp <= mtimecmp_wdata;
        end
    end

    assign timer_pending = (mtime >= mtimecmp);

endmodule

// File: verilog/trap_ctrl.sv
`timescale 1ns/10ps

module trap_ctrl (
    input  logic                clk,
    input  logic                rst_n,

    // retire stage
    input  logic                inst_valid,
    input  csr_pkg::xlen_t      inst_pc,
    input  logic                is_ecall,
    input  logic                is_ebreak,
    input  logic                is_illegal,
    input  logic                is_mret,

    input  logic                timer_pending,
    input  logic                int_en,
    input  csr_pkg::xlen_t      csr_mtvec,
    input  csr_pkg::xlen_t      csr_mepc,

    // to csr_reg
    output logic                trap_enter,
    output logic                trap_return,
    output trap_pkg::cause_t    trap_cause,
    output csr_pkg::xlen_t      trap_epc,

    // to fetch
    output logic                redirect,
    output csr_pkg::xlen_t      redirect_pc
);

    trap_pkg::trap_state_t state;
    trap_pkg::trap_state_t state_nxt;

    logic             take_int;
    logic             take_ill;
    logic             take_brk;
    logic             take_ecall;
    csr_pkg::xlen_t   vec_base;
    trap_pkg::cause_t cause_code;
    csr_pkg::xlen_t   target_pc;

    // source qualification, interrupt first
    assign take_int   = inst_valid & timer_pending & int_en;
    assign take_ill   = inst_valid & is_illegal;
    assign take_brk   = inst_valid & is_ebreak;
    assign take_ecall = inst_valid & is_ecall;

    assign trap_enter  = take_int | take_ill | take_brk | take_ecall;
    assign trap_return = inst_valid & is_mret & ~trap_enter;

    always_comb begin
        if (take_int) begin
            trap_cause = trap_pkg::INT_FLAG | trap_pkg::CAUSE_TIMER_M;
        end else if (take_ill) begin
            trap_cause = trap_pkg::CAUSE_ILLEGAL;
        end else if (take_brk) begin
            trap_cause = trap_pkg::CAUSE_BREAKPOINT;
        end else begin
            trap_cause = trap_pkg::CAUSE_ECALL_M;
        end
    end

    // every trap saves the retiring pc
    assign trap_epc = inst_pc;

    // target from pre-edge csr values
    assign vec_base   = {csr_mtvec[csr_pkg::XLEN-1:2], 2'b00};
    assign cause_code = trap_cause & ~trap_pkg::INT_FLAG;

    always_comb begin
        if (trap_return) begin
            target_pc = csr_mepc;
        end else if (take_int && csr_mtvec[1:0] == trap_pkg::MODE_VECTORED) begin
            target_pc = vec_base + (cause_code << 2);
        end else begin
            target_pc = vec_base;
        end
    end

    assign state_nxt = (trap_enter || trap_return) ? trap_pkg::ST_REDIRECT
                                                   : trap_pkg::ST_IDLE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= trap_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        redirect_pc <= target_pc;
    end

    // one cycle after the decision
    assign redirect = (state == trap_pkg::ST_REDIRECT);

endmodule

// File: verilog/csr_subsys.sv
`timescale 1ns/10ps

module csr_subsys #(
    parameter int XLEN      = csr_pkg::XLEN,
    parameter int MTIME_DIV = 4
) (
    input  logic                clk,
    input  logic                rst_n,

    // csr instruction port
    input  csr_pkg::csr_addr_t  csr_addr,
    input  csr_pkg::csr_op_t    csr_op,
    input  logic                csr_wen,
    input  csr_pkg::xlen_t      rs1,
    output csr_pkg::xlen_t      csr_rdata,

    // retire strobes
    input  logic                inst_valid,
    input  csr_pkg::xlen_t      inst_pc,
    input  logic                is_ecall,
    input  logic                is_ebreak,
    input  logic                is_illegal,
    input  logic                is_mret,

    // timer compare write
    input  logic                mtimecmp_wen,
    input  csr_pkg::xlen_t      mtimecmp_wdata,

    output logic                redirect,
    output csr_pkg::xlen_t      redirect_pc,
    output logic                int_en,
    output csr_pkg::xlen_t      mtime
);

    logic             timer_pending;
    logic             trap_enter;
    logic             trap_return;
    trap_pkg::cause_t trap_cause;
    csr_pkg::xlen_t   trap_epc;
    csr_pkg::xlen_t   csr_mtvec;
    csr_pkg::xlen_t   csr_mepc;

    csr_reg #(
        .XLEN (XLEN)
    ) i_csr_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_addr    (csr_addr),
        .csr_op      (csr_op),
        .csr_wen     (csr_wen),
        .rs1         (rs1),
        .csr_rdata   (csr_rdata),
        .trap_enter  (trap_enter),
        .trap_return (trap_return),
        .trap_cause  (trap_cause),
        .trap_epc    (trap_epc),
        .csr_mtvec   (csr_mtvec),
        .csr_mepc    (csr_mepc),
        .int_en      (int_en)
    );

    mtimer #(
        .MTIME_DIV (MTIME_DIV)
    ) i_mtimer (
        .clk            (clk),
        .rst_n          (rst_n),
        .mtimecmp_wen   (mtimecmp_wen),
        .mtimecmp_wdata (mtimecmp_wdata),
        .mtime          (mtime),
        .timer_pending  (timer_pending)
    );

    trap_ctrl i_trap_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_valid    (inst_valid),
        .inst_pc       (inst_pc),
        .is_ecall      (is_ecall),
        .is_ebreak     (is_ebreak),
        .is_illegal    (is_illegal),
        .is_mret       (is_mret),
        .timer_pending (timer_pending),
        .int_en        (int_en),
        .csr_mtvec     (csr_mtvec),
        .csr_mepc      (csr_mepc),
        .trap_enter    (trap_enter),
        .trap_return   (trap_return),
        .trap_cause    (trap_cause),
        .trap_epc      (trap_epc),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc)
    );

endmodule

// File: tb/tb_csr_subsys.sv
`timescale 1ns/10ps

module tb_csr_subsys;

    localparam int NUM_FIELDS   = 13;
    localparam int MAX_VECTORS  = 64;
    localparam int RESET_CYCLES = 8;
    localparam int RAND_ROUNDS  = 6;
    localparam int MTIME_DIV    = 4;
    // six csr cycles per random round
    localparam int RAND_CYCLES  = RAND_ROUNDS * 6;

    logic               clk;
    logic               rst_n;
    csr_pkg::csr_addr_t csr_addr;
    csr_pkg::csr_op_t   csr_op;
    logic               csr_wen;
    csr_pkg::xlen_t     rs1;
    csr_pkg::xlen_t     csr_rdata;
    logic               inst_valid;
    csr_pkg::xlen_t     inst_pc;
    logic               is_ecall;
    logic               is_ebreak;
    logic               is_illegal;
    logic               is_mret;
    logic               mtimecmp_wen;
    csr_pkg::xlen_t     mtimecmp_wdata;
    logic               redirect;
    csr_pkg::xlen_t     redirect_pc;
    logic               int_en;
    csr_pkg::xlen_t     mtime;

    logic [63:0] vec_mem [0:MAX_VECTORS-1][0:NUM_FIELDS-1];
    int          vec_count;
    int          value_errors;
    int          input_errors;
    int          edge_count;
    bit          vectors_loaded;
    string       step_name;
    integer      seed;

    csr_subsys #(.MTIME_DIV(MTIME_DIV)) i_csr_subsys (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // rising edges seen out of reset
    always @(posedge clk) begin
        if (!rst_n) begin
            edge_count <= 0;
        end else begin
            edge_count <= edge_count + 1;
        end
    end

    task automatic idle_inputs();
        csr_addr       = '0;
        csr_op         = csr_pkg::CSR_NONE;
        csr_wen        = 1'b0;
        rs1            = '0;
        inst_valid     = 1'b0;
        inst_pc        = '0;
        is_ecall       = 1'b0;
        is_ebreak      = 1'b0;
        is_illegal     = 1'b0;
        is_mret        = 1'b0;
        mtimecmp_wen   = 1'b0;
        mtimecmp_wdata = '0;
    endtask

    task automatic load_vectors();
        integer      fd;
        integer      cnt;
        int          line_no;
        string       line;
        logic [63:0] fld [0:NUM_FIELDS-1];
        vec_count = 0;
        line_no = 0;
        fd = $fopen("tb/csr_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file tb/csr_testdata.txt");
            input_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            line_no++;
            if (cnt <= 0 || line.getc(0) == "#") continue;
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                          fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                          fld[7], fld[8], fld[9], fld[10], fld[11], fld[12]);
            // blank line
            if (cnt <= 0) continue;
            if (cnt != NUM_FIELDS || vec_count == MAX_VECTORS) begin
                $display("test data line %0d is malformed or over the table size", line_no);
                input_errors++;
            end else begin
                for (int k = 0; k < NUM_FIELDS; k++) begin
                    vec_mem[vec_count][k] = fld[k];
                end
                vec_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_value(input string field, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns, %s: %s got %h expected %h",
                     $time, step_name, field, got, exp);
            value_errors++;
        end
    endtask

    task automatic drive_vector(input int n);
        logic [63:0] strb;
        strb = vec_mem[n][4];
        idle_inputs();
        csr_addr   = vec_mem[n][0][11:0];
        csr_op     = csr_pkg::csr_op_t'(vec_mem[n][1][1:0]);
        csr_wen    = vec_mem[n][2][0];
        rs1        = vec_mem[n][3];
        inst_valid = strb[0];
        is_ecall   = strb[1];
        is_ebreak  = strb[2];
        is_illegal = strb[3];
        is_mret    = strb[4];
        inst_pc    = vec_mem[n][5];
        // mode 2 puts the compare just ahead of the running timer
        mtimecmp_wen = (vec_mem[n][6] != 64'd0);
        if (vec_mem[n][6] == 64'd2) begin
            mtimecmp_wdata = mtime + vec_mem[n][7];
        end else begin
            mtimecmp_wdata = vec_mem[n][7];
        end
    endtask

    task automatic check_vector(input int n);
        logic [63:0] mask;
        mask = vec_mem[n][12];
        step_name = $sformatf("vector %0d", n);
        if (mask[0]) check_value("csr_rdata", csr_rdata, vec_mem[n][8]);
        if (mask[1]) check_value("redirect", {63'd0, redirect}, vec_mem[n][9]);
        if (mask[2]) check_value("redirect_pc", redirect_pc, vec_mem[n][10]);
        if (mask[3]) check_value("int_en", {63'd0, int_en}, vec_mem[n][11]);
        check_value("mtime", mtime, 64'(edge_count / MTIME_DIV));
    endtask

    task automatic csr_cycle(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_op_t op,
                             input csr_pkg::xlen_t data, input bit do_check,
                             input csr_pkg::xlen_t expected);
        @(posedge clk);
        #5;
        idle_inputs();
        csr_addr = addr;
        csr_op   = op;
        csr_wen  = (op != csr_pkg::CSR_NONE);
        rs1      = data;
        #90;
        if (do_check) check_value("csr_rdata", csr_rdata, expected);
        check_value("mtime", mtime, 64'(edge_count / MTIME_DIV));
    endtask

    task automatic random_readback();
        csr_pkg::xlen_t shadow_mtvec;
        csr_pkg::xlen_t shadow_mepc;
        csr_pkg::xlen_t val;
        for (int r = 0; r < RAND_ROUNDS; r++) begin
            step_name = $sformatf("random round %0d", r);
            shadow_mtvec = {$random(seed), $random(seed)};
            csr_cycle(csr_pkg::ADDR_MTVEC, csr_pkg::CSR_WRITE, shadow_mtvec, 1'b0, '0);
            shadow_mepc = {$random(seed), $random(seed)};
            csr_cycle(csr_pkg::ADDR_MEPC, csr_pkg::CSR_WRITE, shadow_mepc, 1'b0, '0);
            val = {$random(seed), $random(seed)};
            csr_cycle(csr_pkg::ADDR_MTVEC, csr_pkg::CSR_SET, val, 1'b1, shadow_mtvec);
            shadow_mtvec = shadow_mtvec | val;
            val = {$random(seed), $random(seed)};
            csr_cycle(csr_pkg::ADDR_MEPC, csr_pkg::CSR_CLEAR, val, 1'b1, shadow_mepc);
            shadow_mepc = shadow_mepc & ~val;
            csr_cycle(csr_pkg::ADDR_MTVEC, csr_pkg::CSR_NONE, '0, 1'b1, shadow_mtvec);
            csr_cycle(csr_pkg::ADDR_MEPC, csr_pkg::CSR_NONE, '0, 1'b1, shadow_mepc);
        end
    endtask

    initial begin
        seed = 85;
        value_errors = 0;
        input_errors = 0;
        step_name = "";
        vectors_loaded = 1'b0;
        rst_n = 1'b0;
        idle_inputs();
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        rst_n = 1'b1;
        if (input_errors == 0) begin
            for (int n = 0; n < vec_count; n++) begin
                @(posedge clk);
                #5;
                drive_vector(n);
                #90;
                check_vector(n);
            end
            random_readback();
        end
        $display("errors: %0d value mismatches, %0d test data problems",
                 value_errors, input_errors);
        if (value_errors == 0 && input_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // limit follows the vector count, the random rounds and reset
    initial begin
        longint limit_ns;
        wait (vectors_loaded);
        limit_ns = (vec_count + RAND_CYCLES + RESET_CYCLES) * 100 + 2000;
        #(limit_ns);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: csr_subsys.f
verilog/csr_pkg.sv
verilog/trap_pkg.sv
verilog/csr_reg.sv
verilog/mtimer.sv
verilog/trap_ctrl.sv
verilog/csr_subsys.sv
tb/tb_csr_subsys.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_csr_subsys \
    -f csr_subsys.f -o sim_csr_subsys \
    && ./obj_dir/sim_csr_subsys > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

// File: tb/csr_testdata.txt
# addr op wen rs1 strobe pc tmode tdata exp_rdata exp_redirect exp_redirect_pc exp_int_en mask
# strobe 1 valid 2 ecall 4 ebreak 8 illegal 10 mret, tmode 1 load 2 mtime+tdata, mask 1 rdata 2 redirect 4 pc 8 int_en
300 0 0 0         00 0    0 0                a00001800        0 0    0 b
341 0 0 0         00 0    0 0                80000000         0 0    0 b
305 2 1 1000      00 0    0 0                0                0 0    0 b
342 2 1 ff        00 0    0 0                0                0 0    0 b
123 2 1 ffff      00 0    0 0                0                0 0    0 b
123 0 0 0         00 0    0 0                0                0 0    0 b
305 3 1 30        00 0    0 0                1000             0 0    0 b
305 1 1 30        00 0    0 0                1030             0 0    0 b
341 2 1 2000      00 0    0 0                80000000         0 0    0 b
341 3 1 5         00 0    0 0                2000             0 0    0 b
341 1 1 4         00 0    0 0                2005             0 0    0 b
341 0 0 0         00 0    0 0                2001             0 0    0 b
342 3 1 100       00 0    0 0                ff               0 0    0 b
342 1 1 f0        00 0    0 0                1ff              0 0    0 b
342 0 1 123       00 0    0 0                10f              0 0    0 b
300 2 1 a00001888 00 0    0 0                a00001800        0 0    0 b
300 1 1 80        00 0    0 0                a00001888        0 0    1 b
342 0 0 0         03 4000 0 0                0                0 0    1 b
341 0 0 0         00 0    0 0                4000             1 1000 0 f
342 0 0 0         00 0    0 0                b                0 0    0 b
300 0 0 0         05 4100 0 0                a00001880        0 0    0 b
342 0 0 0         00 0    0 0                3                1 1000 0 f
341 0 0 0         00 0    0 0                4100             0 0    0 b
300 0 0 0         11 4104 0 0                a00001800        0 0    0 b
300 0 0 0         11 4108 0 0                a00001880        1 4100 0 f
305 2 1 9999      09 4200 0 0                1000             1 4100 1 f
305 0 0 0         00 0    0 0                1000             1 1000 0 f
342 0 0 0         00 0    0 0                2                0 0    0 b
341 0 0 0         00 0    0 0                4200             0 0    0 b
300 0 0 0         00 0    0 0                a00001880        0 0    0 b
305 2 1 1001      00 0    2 1                1000             0 0    0 b
305 0 0 0         00 0    0 0                1001             0 0    0 b
305 0 0 0         00 0    0 0                1001             0 0    0 b
305 0 0 0         00 0    0 0                1001             0 0    0 b
305 0 0 0         00 0    0 0                1001             0 0    0 b
305 0 0 0         01 5000 0 0                1001             0 0    0 b
300 3 1 8         00 0    0 0                a00001880        0 0    0 b
300 0 0 0         03 5100 0 0                a00001888        0 0    1 b
342 0 0 0         00 0    0 0                8000000000000007 1 101c 0 f
341 0 0 0         00 0    0 0                5100             0 0    0 b
305 2 1 1000      00 0    0 0                1001             0 0    0 b
300 0 0 0         11 6000 0 0                a00001880        0 0    0 b
342 0 0 0         01 6100 0 0                8000000000000007 1 5100 1 f
341 0 0 0         00 0    0 0                6100             1 1000 0 f
300 0 0 0         00 0    1 ffffffffffffffff a00001880        0 0    0 b
300 3 1 8         00 0    0 0                a00001880        0 0    0 b
300 0 0 0         01 7000 0 0                a00001888        0 0    1 b
300 0 0 0         00 0    0 0                a00001888        0 0    1 b
